// ==== tests/platform_stimulus.txt ====
# kind op address mask data expected, all numbers in hex
# address is a word address, except for fetch where it is the byte pc
probe write 010 f 11223344 0
probe write 010 5 aabbccdd 0
probe read 010 0 0 11bb33dd
probe write 011 f 00000000 0
probe write 011 a 55667788 0
probe read 011 0 0 55007700
cpu write 020 f cafef00d 0
cpu read 020 0 0 cafef00d
cpu wblk 020 f deadbeef 0
cpu rblk 020 0 0 0
cpu read 020 0 0 cafef00d
fetch word 80 0 0 cafef00d
fetch word 40 0 0 11bb33dd
probe write 000 f 12345678 0
probe write 400 f ffffffff 0
probe read 400 0 0 0
cpu write 1000 f 87654321 0
cpu read 801 0 0 0
probe read 000 0 0 12345678
probe fill 3ff f 0 0
probe readm 3ff 0 0 0
uart send 800 f 0 0
uart send 800 f 0 0

// ==== sim.f ====
logic/common_pkg.sv
logic/memory_bus_pkg.sv
logic/master_bus_mux.sv
logic/slave_bus_mux.sv
logic/data_mem.sv
logic/uart_tx.sv
logic/platform_top.sv
tests/platform_props.sv
tests/platform_tb.sv

// ==== tests/platform_tb.sv ====
module platform_tb
   import common_pkg::*;
   import memory_bus_pkg::*;
();

   localparam int MEM_WORDS    = 1024;
   localparam int UART_BASE    = 'h800;
   localparam int CLKS_PER_BIT = 8;
   localparam int HALF         = 20;

   logic      clk;
   logic      rst;
   logic      probe_mem;
   word_addr  probe_address;
   logic      probe_mem_read;
   logic      probe_mem_write;
   byte_mask  probe_mask_byte;
   uint32     probe_write_data;
   uint32     probe_read_data;
   bus_cmd    cpu_cmd;
   bus_result cpu_result;
   uint32     pc;
   uint32     instruction;
   logic      invalid_address;
   logic      tx;

   uint32     model_mem [MEM_WORDS];                 // Expected memory contents.
   uint32     lfsr = 32'h6234540b;
   int        limit_cycles = 0;
   string     lines [$];

   platform_top #(
      .MEM_WORDS    (MEM_WORDS),
      .UART_BASE    (UART_BASE),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_dut (.*);

   always #HALF clk = ~clk;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "Run stopped at the first error.");
   endtask

   task automatic check_result(input string name, input bus_result exp, input bus_result act);
      if (act !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s expected %h, actual %h",
                                 $time, name, exp, act));
      end
   endtask

   task automatic check_word(input string name, input uint32 exp, input uint32 act);
      if (act !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s expected %h, actual %h",
                                 $time, name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s expected %b, actual %b",
                                 $time, name, exp, act));
      end
   endtask

   function automatic uint32 random_bits(input int n);
      uint32 v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1; // Galois step.
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic bus_cmd make_cmd(input bus_op op, input uint32 addr,
                                       input byte_mask m, input uint32 d);
      bus_cmd c;
      c.address    = addr[29:0];
      c.mem_read   = (op == op_read);
      c.mem_write  = (op == op_write);
      c.mask_byte  = m;
      c.write_data = d;
      return c;
   endfunction

   task automatic drive_idle();
      probe_mem_read    = 1'b0;
      probe_mem_write   = 1'b0;
      cpu_cmd.mem_read  = 1'b0;
      cpu_cmd.mem_write = 1'b0;
   endtask

   task automatic drive_bus(input logic to_probe, input bus_cmd c);
      if (to_probe) begin
         probe_address    = c.address;
         probe_mem_read   = c.mem_read;
         probe_mem_write  = c.mem_write;
         probe_mask_byte  = c.mask_byte;
         probe_write_data = c.write_data;
      end else begin
         cpu_cmd = c;
      end
   endtask

   task automatic model_write(input uint32 addr, input byte_mask m, input uint32 d);
      for (int i = 0; i < 4; i++) begin
         if (m[i]) begin
            model_mem[addr][8*i +: 8] = d[8*i +: 8];   // Masked lanes keep old bytes.
         end
      end
   endtask

   task automatic run_bus_line(input string kind, input string op, input uint32 addr,
                               input uint32 mask, input uint32 data, input uint32 exp);
      bus_op     cls;
      logic      blocked;
      logic      inv_exp;
      uint32     wdata;
      uint32     want;
      bus_result res_exp;
      cls       = (op == "read" || op == "rblk" || op == "readm") ? op_read : op_write;
      blocked   = (op == "wblk" || op == "rblk");       // CPU while the probe owns the bus.
      wdata     = (op == "fill") ? random_bits(32) : data;
      probe_mem = (kind == "probe") || blocked;
      drive_bus(kind == "probe", make_cmd(cls, addr, mask[3:0], wdata));
      #(HALF / 2);
      inv_exp = !blocked && !(addr < MEM_WORDS) && (addr != UART_BASE);
      check_flag("invalid_address", inv_exp, invalid_address);
      if (cls == op_write && !inv_exp && !blocked) begin
         model_write(addr, mask[3:0], wdata);
      end
      if (cls == op_read) begin
         want              = (op == "readm") ? model_mem[addr] : exp;
         res_exp.read_data = (kind == "probe") ? 32'h0 : want;
         check_result("cpu_result", res_exp, cpu_result);
         check_word("probe_read_data", (kind == "probe") ? want : 32'h0, probe_read_data);
      end
   endtask

   // Negedge n counts from the accepting edge. Mid bit sits at n = 8k + 4.
   task automatic send_uart();
      uint32 b;
      logic  want;
      b         = random_bits(8);
      probe_mem = 1'b1;
      drive_bus(1'b1, make_cmd(op_write, UART_BASE, 4'hf, b));
      for (int n = 1; n <= 96; n++) begin
         @(negedge clk);
         drive_idle();
         if (n % 8 == 4 && n < 80) begin
            want = (n < 8) ? 1'b0 : (n > 72) ? 1'b1 : b[n / 8 - 1];
            check_flag("tx", want, tx);
         end else if (n > 81) begin
            check_flag("tx", 1'b1, tx);                 // No second frame.
         end
         if (n == 2 || n == 81) begin
            drive_bus(1'b1, make_cmd(op_read, UART_BASE, 4'h0, 32'h0));
            #(HALF / 2);
            check_flag("busy", n == 2, probe_read_data[0]);
         end else if (n == 20) begin
            drive_bus(1'b1, make_cmd(op_write, UART_BASE, 4'hf, ~b));
         end
      end
   endtask

   initial begin
      int    fd;
      int    uart_lines;
      string line;
      string kind;
      string op;
      uint32 addr;
      uint32 mask;
      uint32 data;
      uint32 exp;
      clk        = 1'b0;
      rst        = 1'b1;
      probe_mem  = 1'b1;
      probe_address    = '0;
      probe_mem_read   = 1'b0;
      probe_mem_write  = 1'b0;
      probe_mask_byte  = '0;
      probe_write_data = '0;
      cpu_cmd    = '0;
      pc         = '0;
      uart_lines = 0;
      fd = $fopen("tests/platform_stimulus.txt", "r");
      if (fd == 0) begin
         stop_on_error("Cannot open the stimulus file tests/platform_stimulus.txt.");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            lines.push_back(line);
            if (line.substr(0, 3) == "uart") uart_lines++;
         end
      end
      $fclose(fd);
      limit_cycles = lines.size() + 10 * CLKS_PER_BIT * uart_lines + 100;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      foreach (lines[i]) begin
         @(negedge clk);
         drive_idle();
         if ($sscanf(lines[i], "%s %s %h %h %h %h", kind, op, addr, mask, data, exp) != 6) begin
            stop_on_error($sformatf("Stimulus line cannot be parsed: %s", lines[i]));
         end
         if (kind == "fetch") begin
            pc = addr;                                  // Byte address.
            #(HALF / 2);
            check_word("instruction", exp, instruction);
         end else if (kind == "uart") begin
            send_uart();
         end else if (kind == "probe" || kind == "cpu") begin
            run_bus_line(kind, op, addr, mask, data, exp);
         end else begin
            stop_on_error($sformatf("Unknown command kind in stimulus: %s", kind));
         end
      end
      @(negedge clk);
      drive_idle();
      $display("Simulation PASSED");
      $finish;
   end

   initial begin
      wait (u_dut.u_props.assert_fails != 0);
      stop_on_error("A bound assertion failed during the run.");
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      stop_on_error("Timeout: the run did not finish within the expected number of cycles.");
   end

endmodule

// ==== tests/platform_props.sv ====
module platform_props
   import memory_bus_pkg::*;
(
   input logic      clk,
   input logic      rst,
   input bus_cmd    mem_cmd,
   input bus_cmd    uart_cmd,
   input logic      invalid_address,
   input logic      tx,
   input uart_state tx_state
);

   int assert_fails = 0;

   function automatic bus_op op_of(input bus_cmd c);
      if (c.mem_write) return op_write;
      if (c.mem_read) return op_read;
      return op_idle;
   endfunction

   // At most one device is addressed per cycle.
   a_one_device: assert property (@(posedge clk) disable iff (rst)
      !(op_of(mem_cmd) != op_idle && op_of(uart_cmd) != op_idle))
      else begin
         assert_fails++;
         $error("Memory and UART strobed in the same cycle.");
      end

   a_idle_line: assert property (@(posedge clk) disable iff (rst)
      tx_state == tx_idle |-> tx)
      else begin
         assert_fails++;
         $error("UART line low while the transmitter is idle.");
      end

   a_invalid_quiet: assert property (@(posedge clk) disable iff (rst)
      invalid_address |-> op_of(mem_cmd) == op_idle && op_of(uart_cmd) == op_idle)
      else begin
         assert_fails++;
         $error("A device was strobed on an invalid address.");
      end

endmodule

bind platform_top platform_props u_props (
   .clk             (clk),
   .rst             (rst),
   .mem_cmd         (mem_cmd),
   .uart_cmd        (uart_cmd),
   .invalid_address (invalid_address),
   .tx              (tx),
   .tx_state        (u_uart_tx.state_q)
);

// ==== logic/platform_top.sv ====
module platform_top
   import common_pkg::*;
   import memory_bus_pkg::*;
#(
   parameter int MEM_WORDS    = 1024,
   parameter int UART_BASE    = 'h800,
   parameter int CLKS_PER_BIT = 8
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      probe_mem,
   input  word_addr  probe_address,
   input  logic      probe_mem_read,
   input  logic      probe_mem_write,
   input  byte_mask  probe_mask_byte,
   input  uint32     probe_write_data,
   output uint32     probe_read_data,
   input  bus_cmd    cpu_cmd,
   output bus_result cpu_result,
   input  uint32     pc,
   output uint32     instruction,
   output logic      invalid_address,
   output logic      tx
);

   bus_cmd    probe_cmd;
   bus_result probe_result;
   bus_cmd    common_cmd;
   bus_result common_result;
   bus_cmd    mem_cmd;
   bus_result mem_result;
   bus_cmd    uart_cmd;
   bus_result uart_result;

   // Probe pins packed into a bus command.
   assign probe_cmd.address    = probe_address;
   assign probe_cmd.mem_read   = probe_mem_read;
   assign probe_cmd.mem_write  = probe_mem_write;
   assign probe_cmd.mask_byte  = probe_mask_byte;
   assign probe_cmd.write_data = probe_write_data;
   assign probe_read_data      = probe_result.read_data;

   master_bus_mux u_master_mux (
      .use_a         (probe_mem),                  // Probe takes the bus.
      .a_cmd         (probe_cmd),
      .a_result      (probe_result),
      .b_cmd         (cpu_cmd),
      .b_result      (cpu_result),
      .common_cmd    (common_cmd),
      .common_result (common_result)
   );

   slave_bus_mux #(
      .MEM_BASE  (0),
      .MEM_WORDS (MEM_WORDS),
      .UART_BASE (UART_BASE)
   ) u_slave_mux (
      .cmd_in          (common_cmd),
      .result_out      (common_result),
      .invalid_address (invalid_address),
      .mem_cmd         (mem_cmd),
      .mem_result      (mem_result),
      .uart_cmd        (uart_cmd),
      .uart_result     (uart_result)
   );

   data_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) u_data_mem (
      .clk         (clk),
      .rst         (rst),
      .membuscmd   (mem_cmd),
      .membusres   (mem_result),
      .pc          (pc),
      .instruction (instruction)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_tx (
      .clk        (clk),
      .rst        (rst),
      .uartbuscmd (uart_cmd),
      .uartbusres (uart_result),
      .tx         (tx)
   );

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx
   import memory_bus_pkg::*;
#(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic      clk,
   input  logic      rst,
   input  bus_cmd    uartbuscmd,
   output bus_result uartbusres,
   output logic      tx
);

   localparam int CW = $clog2(CLKS_PER_BIT + 1);

   uart_state      state_q;
   logic [CW-1:0]  clk_cnt_q;
   logic [2:0]     bit_idx_q;
   logic [7:0]     shift_q;
   logic           busy;
   logic           accept;
   logic           bit_end;

   assign busy    = (state_q != tx_idle);
   assign accept  = uartbuscmd.mem_write && !busy; // Writes while busy are dropped.
   assign bit_end = (clk_cnt_q == CW'(CLKS_PER_BIT - 1));

   assign uartbusres.read_data = {31'b0, busy};

   // Shift register holds the byte in flight.
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_q <= uartbuscmd.write_data[7:0];
      end else if (state_q == tx_data && bit_end) begin
         shift_q <= shift_q >> 1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= tx_idle;
         tx        <= 1'b1;                        // Line idles high.
         clk_cnt_q <= '0;
         bit_idx_q <= '0;
      end else begin
         clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
         case (state_q)
            tx_idle: begin
               clk_cnt_q <= '0;
               if (accept) begin
                  state_q <= tx_start;
                  tx      <= 1'b0;                 // Start bit.
               end
            end
            tx_start: begin
               if (bit_end) begin
                  state_q   <= tx_data;
                  tx        <= shift_q[0];
                  bit_idx_q <= '0;
               end
            end
            tx_data: begin
               if (bit_end) begin
                  if (bit_idx_q == 3'd7) begin
                     state_q <= tx_stop;
                     tx      <= 1'b1;              // Stop bit.
                  end else begin
                     bit_idx_q <= bit_idx_q + 1'b1;
                     tx        <= shift_q[1];      // Next bit before the shift lands.
                  end
               end
            end
            tx_stop: begin
               if (bit_end) begin
                  state_q <= tx_idle;
               end
            end
            default: begin
               state_q <= tx_idle;
               tx      <= 1'b1;
            end
         endcase
      end
   end

endmodule

// ==== logic/data_mem.sv ====
module data_mem
   import common_pkg::*;
   import memory_bus_pkg::*;
#(
   parameter int MEM_WORDS = 1024
) (
   input  logic      clk,
   input  logic      rst,
   input  bus_cmd    membuscmd,
   output bus_result membusres,
   input  uint32     pc,
   output uint32     instruction
);

   localparam int AW = $clog2(MEM_WORDS);

   uint32          mem [MEM_WORDS];
   logic [AW-1:0]  bus_idx;
   logic [AW-1:0]  fetch_idx;
   logic           wr_en;
   logic           repeat_wr;
   logic           last_valid_q;
   word_addr       last_addr_q;
   byte_mask       last_mask_q;
   uint32          last_data_q;

   assign bus_idx   = membuscmd.address[AW-1:0];
   assign fetch_idx = pc[AW+1:2];                  // Byte address to word index.

   // A write identical to the one stored on the last edge changes nothing.
   assign repeat_wr = last_valid_q
                   && (last_addr_q == membuscmd.address)
                   && (last_mask_q == membuscmd.mask_byte)
                   && (last_data_q == membuscmd.write_data);
   assign wr_en     = membuscmd.mem_write && !repeat_wr;

   always_ff @(posedge clk) begin
      if (rst) begin
         last_valid_q <= 1'b0;                     // Guard idle after reset.
      end else begin
         last_valid_q <= membuscmd.mem_write;
      end
   end

   always_ff @(posedge clk) begin
      if (membuscmd.mem_write) begin
         last_addr_q <= membuscmd.address;
         last_mask_q <= membuscmd.mask_byte;
         last_data_q <= membuscmd.write_data;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (wr_en && membuscmd.mask_byte[i]) begin
            mem[bus_idx][8*i +: 8] <= membuscmd.write_data[8*i +: 8];
         end
      end
   end

   assign membusres.read_data = membuscmd.mem_read ? mem[bus_idx] : '0;
   assign instruction         = mem[fetch_idx]; // Fetch port, always on.

endmodule

// ==== logic/slave_bus_mux.sv ====
module slave_bus_mux
   import common_pkg::*;
   import memory_bus_pkg::*;
#(
   parameter int MEM_BASE  = 0,
   parameter int MEM_WORDS = 1024,
   parameter int UART_BASE = 'h800
) (
   input  bus_cmd    cmd_in,
   output bus_result result_out,
   output logic      invalid_address,
   output bus_cmd    mem_cmd,
   input  bus_result mem_result,
   output bus_cmd    uart_cmd,
   input  bus_result uart_result
);

   localparam word_addr MEM_LO  = word_addr'(MEM_BASE);
   localparam word_addr MEM_LEN = word_addr'(MEM_WORDS);
   localparam word_addr UART_AT = word_addr'(UART_BASE);

   word_addr mem_offset;
   logic     hit_mem;
   logic     hit_uart;
   logic     strobe;

   assign mem_offset = cmd_in.address - MEM_LO;    // Memory sees addresses from zero.
   assign hit_mem    = (cmd_in.address >= MEM_LO) && (mem_offset < MEM_LEN);
   assign hit_uart   = (cmd_in.address == UART_AT); // One-word window.
   assign strobe     = cmd_in.mem_read | cmd_in.mem_write;

   assign invalid_address = strobe && !hit_mem && !hit_uart;

   always_comb begin
      mem_cmd           = cmd_in;
      mem_cmd.address   = mem_offset;
      mem_cmd.mem_read  = cmd_in.mem_read  & hit_mem;
      mem_cmd.mem_write = cmd_in.mem_write & hit_mem;
   end

   always_comb begin
      uart_cmd           = cmd_in;
      uart_cmd.mem_read  = cmd_in.mem_read  & hit_uart;
      uart_cmd.mem_write = cmd_in.mem_write & hit_uart;
   end

   // Only the hit device drives the shared result.
   always_comb begin
      if (hit_mem) begin
         result_out = mem_result;
      end else if (hit_uart) begin
         result_out = uart_result;
      end else begin
         result_out = '0;                          // Unmapped reads return zero.
      end
   end

endmodule

// ==== logic/master_bus_mux.sv ====
module master_bus_mux
   import memory_bus_pkg::*;
(
   input  logic      use_a,
   input  bus_cmd    a_cmd,
   output bus_result a_result,
   input  bus_cmd    b_cmd,
   output bus_result b_result,
   output bus_cmd    common_cmd,
   input  bus_result common_result
);

   // The selected master owns the bus.
   assign common_cmd = use_a ? a_cmd : b_cmd;

   always_comb begin
      a_result = '0;                               // Idle master reads zero.
      b_result = '0;
      if (use_a) begin
         a_result = common_result;
      end else begin
         b_result = common_result;
      end
   end

endmodule

// ==== logic/memory_bus_pkg.sv ====
package memory_bus_pkg;
   import common_pkg::*;

   // Command issued by a bus master; the result comes back in the same cycle.
   typedef struct packed {
      word_addr address;
      logic     mem_read;
      logic     mem_write;
      byte_mask mask_byte;
      uint32    write_data;
   } bus_cmd;

   typedef struct packed {
      uint32 read_data;
   } bus_result;

   // Coarse class of a bus command.
   typedef enum logic [1:0] {
      op_idle,
      op_read,
      op_write
   } bus_op;

   // Serial states of the UART transmitter.
   typedef enum logic [1:0] {
      tx_idle,                                     // Line high, ready for a write.
      tx_start,                                    // Start bit, line low.
      tx_data,                                     // Eight data bits, LSB first.
      tx_stop                                      // Stop bit, line high.
   } uart_state;

endpackage

// ==== logic/common_pkg.sv ====
package common_pkg;

   // Plain data word on every bus.
   typedef logic [31:0] uint32;

   typedef logic [29:0] word_addr;                 // Word address, byte offset dropped.

   typedef logic [3:0]  byte_mask;                 // One enable per byte lane.

endpackage
